// ==== vlog.f ====
+incdir+verif
common/host_map_pkg.sv
common/eth_slot_pkg.sv
rtl/global_timer.sv
rtl/host_bus_slave.sv
ethpipe/slot_ram.sv
ethpipe/gmii_rx_capture.sv
rtl/ethpipe_top.sv
verif/tb_ethpipe_top.sv

// ==== verif/tb_host_tasks.svh ====
// --------------------------------------------------------------------------
// host bus access, called on a falling edge
// --------------------------------------------------------------------------
function automatic logic [15:0] reg_adr(input logic [2:0] region, input logic [2:0] idx);
  return {region, 9'd0, idx, 1'b0};
endfunction

function automatic logic [15:0] slot_adr(input int w);
  return {REGION_RX1, w[11:0], 1'b0};
endfunction

task automatic run_cycle(input logic [15:0] adr, input logic we, output logic [15:0] rdat);
  int n;
  n = 0;
  bus_adr = adr;
  bus_we  = we;
  bus_cyc = 1'b1;
  bus_stb = 1'b1;
  @(negedge clk_125);
  while (bus_ack !== 1'b1 && n < BUS_TIMEOUT) begin
    @(negedge clk_125);
    n++;
  end
  if (bus_ack !== 1'b1) begin
    $display("bus access to %h got no ack within %0d cycles", adr, BUS_TIMEOUT);
    errors++;
  end
  rdat    = bus_rdat;
  bus_stb = 1'b0;
  bus_cyc = 1'b0;
  bus_we  = 1'b0;
  @(negedge clk_125);
endtask

task automatic write_bus(input logic [15:0] adr, input logic [15:0] dat, input logic [1:0] sel);
  logic [15:0] unused;
  bus_wdat = dat;
  bus_sel  = sel;
  run_cycle(adr, 1'b1, unused);
endtask

task automatic read_bus(input logic [15:0] adr, output logic [15:0] dat);
  bus_sel = 2'b11;
  run_cycle(adr, 1'b0, dat);
endtask

// four consecutive lane registers, lane 0 first
task automatic read_four_lanes(input logic [2:0] region, input logic [2:0] idx0,
                               output logic [63:0] word);
  logic [15:0] v;
  for (int i = 0; i < 4; i++) begin
    read_bus(reg_adr(region, idx0 + 3'(i)), v);
    word[16*i +: 16] = v;
  end
endtask

// --------------------------------------------------------------------------
// GMII side
// --------------------------------------------------------------------------
task automatic send_frame(input int nbytes);
  logic [7:0] b;
  for (int i = 0; i < 8; i++) begin
    gmii_rxd = (i == 7) ? GMII_SFD : GMII_PREAMBLE;
    gmii_dv  = 1'b1;
    @(negedge clk_125);
  end
  for (int i = 0; i < nbytes; i++) begin
    rand_byte(b);
    sent_bytes[i] = b;
    gmii_rxd = b;
    @(negedge clk_125);
  end
  gmii_dv  = 1'b0;
  gmii_rxd = 8'd0;
endtask

task automatic await_irq(input int base);
  int n;
  n = 0;
  while (irq_count == base && n < IRQ_TIMEOUT) begin
    @(negedge clk_125);
    n++;
  end
  if (irq_count == base) begin
    $display("no frame interrupt within %0d cycles at time %0t", IRQ_TIMEOUT, $time);
    errors++;
  end
endtask

// words 0 to 7 sit behind the rx registers
task automatic compare_slot_words(input int nbytes);
  logic [15:0] v;
  logic [15:0] exp;
  for (int w = 8; w < nbytes / 2; w++) begin
    read_bus(slot_adr(w), v);
    exp = {stored_bytes[2*w], stored_bytes[2*w+1]};
    if (v !== exp) begin
      $display("FAILED at %0t: slot word %0d read %h, expected %h", $time, w, v, exp);
      errors++;
    end
  end
endtask

task automatic capture_frame_check(input int nbytes);
  logic [63:0] t_before;
  logic [63:0] t_after;
  logic [63:0] ts;
  logic [15:0] v;
  int          base;
  read_four_lanes(REGION_GLOBAL, REG_COUNTER_0, t_before);
  base = irq_count;
  send_frame(nbytes);
  await_irq(base);
  stored_bytes = sent_bytes;
  stored_len   = nbytes;
  read_four_lanes(REGION_GLOBAL, REG_COUNTER_0, t_after);
  if (irq_count != base + 1) begin
    $display("FAILED at %0t: %0d irq pulses, expected 1", $time, irq_count - base);
    errors++;
  end
  read_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), v);
  if (v !== 16'h0001) begin
    $display("FAILED at %0t: slot status %h after frame, expected 0001", $time, v);
    errors++;
  end
  read_bus(reg_adr(REGION_RX1, REG_RX_LEN), v);
  if (v !== 16'(nbytes)) begin
    $display("FAILED at %0t: frame length %0d, expected %0d", $time, v, nbytes);
    errors++;
  end
  read_four_lanes(REGION_RX1, REG_RX_TS_0, ts);
  if ($isunknown(ts) || ts < t_before || ts > t_after) begin
    $display("FAILED at %0t: timestamp %h outside %h..%h", $time, ts, t_before, t_after);
    errors++;
  end
  compare_slot_words(nbytes);
endtask

// --------------------------------------------------------------------------
// directed tests
// --------------------------------------------------------------------------
task automatic counter_lanes_rw();
  logic [15:0] wval [4];
  logic [15:0] v;
  int          err0;
  err0    = errors;
  wval[0] = 16'h0100;
  wval[1] = 16'h7ace;
  wval[2] = 16'h5a5a;
  wval[3] = 16'hc3a5;
  for (int i = 0; i < 4; i++) begin
    write_bus(reg_adr(REGION_GLOBAL, REG_COUNTER_0 + 3'(i)), wval[i], 2'b11);
  end
  for (int i = 0; i < 4; i++) begin
    read_bus(reg_adr(REGION_GLOBAL, REG_COUNTER_0 + 3'(i)), v);
    if (i == 3 && v !== wval[i]) begin
      $display("FAILED at %0t: counter lane 3 read %h, expected %h", $time, v, wval[i]);
      errors++;
    end
    if (i < 3 && ($isunknown(v) || v < wval[i] || int'(v) > int'(wval[i]) + 20)) begin
      $display("FAILED at %0t: counter lane %0d read %h, written %h", $time, i, v, wval[i]);
      errors++;
    end
  end
  log_test_result("counter lanes", err0);
endtask

task automatic slot_status_rw();
  logic [15:0] v;
  int          err0;
  err0 = errors;
  read_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), v);
  if (v !== 16'h0000) begin
    $display("FAILED at %0t: slot status reset value %h, expected 0000", $time, v);
    errors++;
  end
  write_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), 16'h0002, 2'b11);
  read_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), v);
  if (v !== 16'h0002) begin
    $display("FAILED at %0t: slot status %h after release, expected 0002", $time, v);
    errors++;
  end
  write_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), 16'h000a, 2'b11);
  read_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), v);
  if (v !== 16'h000a) begin
    $display("FAILED at %0t: slot status %h after write, expected 000a", $time, v);
    errors++;
  end
  write_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), 16'h0002, 2'b11);
  read_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), v);
  if (v !== 16'h0002) begin
    $display("FAILED at %0t: slot status %h after second release", $time, v);
    errors++;
  end
  log_test_result("slot status", err0);
endtask

task automatic frame_capture();
  int err0;
  err0 = errors;
  capture_frame_check(60);
  log_test_result("frame capture", err0);
endtask

task automatic full_slot_drop();
  logic [15:0] v;
  int          base;
  int          err0;
  err0 = errors;
  base = irq_count;
  // a length unlike the stored frame, so a wrong capture shows up
  send_frame(52);
  // no pulse may show up once the frame is over
  repeat (DROP_WINDOW) @(negedge clk_125);
  if (irq_count != base) begin
    $display("FAILED at %0t: irq raised for a frame sent into a full slot", $time);
    errors++;
  end
  read_bus(reg_adr(REGION_RX1, REG_RX_LEN), v);
  if (v !== 16'(stored_len)) begin
    $display("FAILED at %0t: length %0d after dropped frame, expected %0d",
             $time, v, stored_len);
    errors++;
  end
  compare_slot_words(stored_len);
  write_bus(reg_adr(REGION_GLOBAL, REG_SLOT_STATUS), 16'h0002, 2'b11);
  capture_frame_check(44);
  log_test_result("full slot drop", err0);
endtask

task automatic window_and_unmapped();
  logic [15:0] v;
  int          err0;
  err0 = errors;
  write_bus(slot_adr(40), 16'h1234, 2'b11);
  read_bus(slot_adr(40), v);
  if (v !== 16'h1234) begin
    $display("FAILED at %0t: slot word 40 read %h, expected 1234", $time, v);
    errors++;
  end
  // sel bit 0 is the upper byte
  write_bus(slot_adr(40), 16'habcd, 2'b01);
  read_bus(slot_adr(40), v);
  if (v !== 16'hab34) begin
    $display("FAILED at %0t: slot word 40 read %h after byte write, expected ab34", $time, v);
    errors++;
  end
  read_bus({3'd2, 13'd0}, v);
  if (v !== 16'h0000) begin
    $display("FAILED at %0t: region 2 read %h, expected 0000", $time, v);
    errors++;
  end
  read_bus(reg_adr(REGION_GLOBAL, 3'd6), v);
  if (v !== 16'h0000) begin
    $display("FAILED at %0t: register index 6 read %h, expected 0000", $time, v);
    errors++;
  end
  log_test_result("slot window and unmapped space", err0);
endtask

// ==== verif/tb_ethpipe_top.sv ====
module tb_ethpipe_top;

  import host_map_pkg::*;
  import eth_slot_pkg::*;

  localparam int          BUS_TIMEOUT = 16;
  localparam int          IRQ_TIMEOUT = 40;
  localparam int          DROP_WINDOW = 12;
  localparam logic [31:0] LFSR_SEED   = 32'haa472ba9;

  logic        clk_125;
  logic        core_rst_n;
  logic [15:0] bus_adr;
  logic [15:0] bus_wdat;
  logic [1:0]  bus_sel;
  logic        bus_we;
  logic        bus_cyc;
  logic        bus_stb;
  logic [15:0] bus_rdat;
  logic        bus_ack;
  logic [7:0]  gmii_rxd;
  logic        gmii_dv;
  logic        rx_irq;

  logic [31:0] lfsr_state;
  int          errors;
  int          tests_run;
  int          irq_count;

  // bytes of the last frame sent, and of the last frame the slot accepted
  logic [7:0]  sent_bytes [64];
  logic [7:0]  stored_bytes [64];
  int          stored_len;

  initial begin
    clk_125 = 1'b0;
    forever begin
      #10 clk_125 = ~clk_125;
    end
  end

  ethpipe_top u_ethpipe_top (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .bus_adr_i      (bus_adr),
    .bus_dat_i      (bus_wdat),
    .bus_sel_i      (bus_sel),
    .bus_we_i       (bus_we),
    .bus_cyc_i      (bus_cyc),
    .bus_stb_i      (bus_stb),
    .bus_dat_o      (bus_rdat),
    .bus_ack_o      (bus_ack),
    .gmii_rxd_i     (gmii_rxd),
    .gmii_rx_dv_i   (gmii_dv),
    .rx_frame_irq_o (rx_irq)
  );

  // irq pulses counted on the falling edge
  always @(negedge clk_125) begin
    if (rx_irq === 1'b1) begin
      irq_count++;
    end
  end

  // --------------------------------------------------------------------------
  // payload source, x^32 + x^22 + x^2 + x + 1
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = 8'd0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic log_test_result(input string name, input int err0);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
  endtask

  `include "tb_host_tasks.svh"

  initial begin
    core_rst_n = 1'b0;
    bus_adr    = 16'd0;
    bus_wdat   = 16'd0;
    bus_sel    = 2'b00;
    bus_we     = 1'b0;
    bus_cyc    = 1'b0;
    bus_stb    = 1'b0;
    gmii_rxd   = 8'd0;
    gmii_dv    = 1'b0;
    lfsr_state = LFSR_SEED;
    errors     = 0;
    tests_run  = 0;
    irq_count  = 0;
    stored_len = 0;

    repeat (4) @(negedge clk_125);
    core_rst_n = 1'b1;
    @(negedge clk_125);

    counter_lanes_rw();
    slot_status_rw();
    frame_capture();
    full_slot_drop();
    window_and_unmapped();

    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== rtl/ethpipe_top.sv ====
module ethpipe_top (
  input  logic                               clk_125,
  input  logic                               core_rst_n,
  input  logic [host_map_pkg::BUS_AW-1:0]    bus_adr_i,
  input  logic [host_map_pkg::BUS_DW-1:0]    bus_dat_i,
  input  logic [host_map_pkg::BUS_SELW-1:0]  bus_sel_i,
  input  logic                               bus_we_i,
  input  logic                               bus_cyc_i,
  input  logic                               bus_stb_i,
  output logic [host_map_pkg::BUS_DW-1:0]    bus_dat_o,
  output logic                               bus_ack_o,
  input  logic [7:0]                         gmii_rxd_i,
  input  logic                               gmii_rx_dv_i,
  output logic                               rx_frame_irq_o
);

  import host_map_pkg::*;
  import eth_slot_pkg::*;

  counter_word_u          count;
  logic [3:0]             lane_we;
  logic [BUS_SELW-1:0]    lane_sel;
  logic [BUS_DW-1:0]      lane_dat;

  counter_word_u          rx_timestamp;
  logic [FRAME_LEN_W-1:0] rx_frame_len;
  logic                   frame_ready;
  logic                   slot_empty;

  // slot port a is the host side, port b the receiver
  logic [SLOT_AW-1:0]     a_addr;
  logic [SLOT_DW-1:0]     a_wdat;
  logic [SLOT_DW/8-1:0]   a_be;
  logic                   a_we;
  logic [SLOT_DW-1:0]     a_rdat;
  logic [SLOT_AW-1:0]     b_addr;
  logic [SLOT_DW-1:0]     b_wdat;
  logic [SLOT_DW/8-1:0]   b_be;
  logic                   b_we;

  global_timer u_global_timer (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .lane_we_i  (lane_we),
    .lane_sel_i (lane_sel),
    .lane_dat_i (lane_dat),
    .count_o    (count)
  );

  host_bus_slave u_host_bus_slave (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .bus_adr_i      (bus_adr_i),
    .bus_dat_i      (bus_dat_i),
    .bus_sel_i      (bus_sel_i),
    .bus_we_i       (bus_we_i),
    .bus_cyc_i      (bus_cyc_i),
    .bus_stb_i      (bus_stb_i),
    .bus_dat_o      (bus_dat_o),
    .bus_ack_o      (bus_ack_o),
    .count_i        (count),
    .lane_we_o      (lane_we),
    .lane_sel_o     (lane_sel),
    .lane_dat_o     (lane_dat),
    .rx_timestamp_i (rx_timestamp),
    .rx_frame_len_i (rx_frame_len),
    .frame_ready_i  (frame_ready),
    .slot_empty_o   (slot_empty),
    .ram_addr_o     (a_addr),
    .ram_wdat_o     (a_wdat),
    .ram_be_o       (a_be),
    .ram_we_o       (a_we),
    .ram_rdat_i     (a_rdat),
    .rx_frame_irq_o (rx_frame_irq_o)
  );

  slot_ram u_slot_ram (
    .clk_125  (clk_125),
    .a_addr_i (a_addr),
    .a_wdat_i (a_wdat),
    .a_be_i   (a_be),
    .a_we_i   (a_we),
    .a_rdat_o (a_rdat),
    .b_addr_i (b_addr),
    .b_wdat_i (b_wdat),
    .b_be_i   (b_be),
    .b_we_i   (b_we),
    .b_rdat_o ()
  );

  gmii_rx_capture u_gmii_rx_capture (
    .clk_125       (clk_125),
    .core_rst_n    (core_rst_n),
    .gmii_rxd_i    (gmii_rxd_i),
    .gmii_rx_dv_i  (gmii_rx_dv_i),
    .count_i       (count),
    .slot_empty_i  (slot_empty),
    .wr_addr_o     (b_addr),
    .wr_dat_o      (b_wdat),
    .wr_be_o       (b_be),
    .wr_we_o       (b_we),
    .timestamp_o   (rx_timestamp),
    .frame_len_o   (rx_frame_len),
    .frame_ready_o (frame_ready)
  );

endmodule

// ==== ethpipe/gmii_rx_capture.sv ====
module gmii_rx_capture (
  input  logic                                    clk_125,
  input  logic                                    core_rst_n,
  input  logic [7:0]                              gmii_rxd_i,
  input  logic                                    gmii_rx_dv_i,
  input  logic [63:0]                             count_i,
  input  logic                                    slot_empty_i,
  output logic [eth_slot_pkg::SLOT_AW-1:0]        wr_addr_o,
  output logic [eth_slot_pkg::SLOT_DW-1:0]        wr_dat_o,
  output logic [eth_slot_pkg::SLOT_DW/8-1:0]      wr_be_o,
  output logic                                    wr_we_o,
  output logic [63:0]                             timestamp_o,
  output logic [eth_slot_pkg::FRAME_LEN_W-1:0]    frame_len_o,
  output logic                                    frame_ready_o
);

  import eth_slot_pkg::*;

  logic                   busy_q;
  logic                   drop_q;
  logic [FRAME_LEN_W-1:0] len_q;
  logic [63:0]            ts_q;
  logic                   wr_we_q;
  logic                   frame_ready_q;
  logic [SLOT_AW-1:0]     wr_addr_q;
  logic [SLOT_DW-1:0]     wr_dat_q;
  logic [1:0]             wr_be_q;

  // ------------------------------------------------------------------------
  // framing
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      busy_q        <= 1'b0;
      drop_q        <= 1'b0;
      len_q         <= '0;
      ts_q          <= 64'd0;
      wr_we_q       <= 1'b0;
      frame_ready_q <= 1'b0;
    end else begin
      wr_we_q       <= 1'b0;
      frame_ready_q <= 1'b0;
      if (busy_q) begin
        if (gmii_rx_dv_i) begin
          // bytes past the limit are lost
          if (len_q < MAX_FRAME_BYTES) begin
            wr_we_q <= 1'b1;
            len_q   <= len_q + 1'b1;
          end
          if (len_q == '0) begin
            ts_q <= count_i;
          end
        end else begin
          busy_q        <= 1'b0;
          frame_ready_q <= 1'b1;
        end
      end else if (drop_q) begin
        if (!gmii_rx_dv_i) begin
          drop_q <= 1'b0;
        end
      end else if (gmii_rx_dv_i) begin
        if (gmii_rxd_i == GMII_SFD) begin
          // no room, discard until dv drops
          if (slot_empty_i) begin
            busy_q <= 1'b1;
            len_q  <= '0;
          end else begin
            drop_q <= 1'b1;
          end
        end else if (gmii_rxd_i != GMII_PREAMBLE) begin
          drop_q <= 1'b1;
        end
      end
    end
  end

  // byte packing, even bytes in the upper half
  always_ff @(posedge clk_125) begin
    if (busy_q && gmii_rx_dv_i) begin
      wr_addr_q <= SLOT_AW'(len_q >> 1);
      wr_dat_q  <= {gmii_rxd_i, gmii_rxd_i};
      wr_be_q   <= {~len_q[0], len_q[0]};
    end
  end

  assign wr_addr_o     = wr_addr_q;
  assign wr_dat_o      = wr_dat_q;
  assign wr_be_o       = wr_be_q;
  assign wr_we_o       = wr_we_q;
  assign timestamp_o   = ts_q;
  assign frame_len_o   = len_q;
  assign frame_ready_o = frame_ready_q;

  // the host must not own the slot while a frame is stored
  write_only_when_empty : assert property (
    @(posedge clk_125) disable iff (!core_rst_n) wr_we_q |-> slot_empty_i
  );

endmodule

// ==== ethpipe/slot_ram.sv ====
module slot_ram (
  input  logic                                clk_125,
  input  logic [eth_slot_pkg::SLOT_AW-1:0]    a_addr_i,
  input  logic [eth_slot_pkg::SLOT_DW-1:0]    a_wdat_i,
  input  logic [eth_slot_pkg::SLOT_DW/8-1:0]  a_be_i,
  input  logic                                a_we_i,
  output logic [eth_slot_pkg::SLOT_DW-1:0]    a_rdat_o,
  input  logic [eth_slot_pkg::SLOT_AW-1:0]    b_addr_i,
  input  logic [eth_slot_pkg::SLOT_DW-1:0]    b_wdat_i,
  input  logic [eth_slot_pkg::SLOT_DW/8-1:0]  b_be_i,
  input  logic                                b_we_i,
  output logic [eth_slot_pkg::SLOT_DW-1:0]    b_rdat_o
);

  import eth_slot_pkg::*;

  localparam int DEPTH = 1 << SLOT_AW;
  localparam int BEW   = SLOT_DW / 8;

  logic [SLOT_DW-1:0] mem [DEPTH];

  // be bit 1 is the upper byte
  always_ff @(posedge clk_125) begin
    for (int b = 0; b < BEW; b++) begin
      if (a_we_i && a_be_i[b]) begin
        mem[a_addr_i][b*8 +: 8] <= a_wdat_i[b*8 +: 8];
      end
      if (b_we_i && b_be_i[b]) begin
        mem[b_addr_i][b*8 +: 8] <= b_wdat_i[b*8 +: 8];
      end
    end
    a_rdat_o <= mem[a_addr_i];
    b_rdat_o <= mem[b_addr_i];
  end

  // host and receiver own the slot at different times
  no_write_collision : assert property (
    @(posedge clk_125) (a_we_i && b_we_i) |-> (a_addr_i != b_addr_i)
  );

endmodule

// ==== rtl/host_bus_slave.sv ====
module host_bus_slave (
  input  logic                                  clk_125,
  input  logic                                  core_rst_n,
  input  logic [host_map_pkg::BUS_AW-1:0]       bus_adr_i,
  input  logic [host_map_pkg::BUS_DW-1:0]       bus_dat_i,
  input  logic [host_map_pkg::BUS_SELW-1:0]     bus_sel_i,
  input  logic                                  bus_we_i,
  input  logic                                  bus_cyc_i,
  input  logic                                  bus_stb_i,
  output logic [host_map_pkg::BUS_DW-1:0]       bus_dat_o,
  output logic                                  bus_ack_o,
  input  host_map_pkg::counter_word_u           count_i,
  output logic [3:0]                            lane_we_o,
  output logic [host_map_pkg::BUS_SELW-1:0]     lane_sel_o,
  output logic [host_map_pkg::BUS_DW-1:0]       lane_dat_o,
  input  host_map_pkg::counter_word_u           rx_timestamp_i,
  input  logic [eth_slot_pkg::FRAME_LEN_W-1:0]  rx_frame_len_i,
  input  logic                                  frame_ready_i,
  output logic                                  slot_empty_o,
  output logic [eth_slot_pkg::SLOT_AW-1:0]      ram_addr_o,
  output logic [eth_slot_pkg::SLOT_DW-1:0]      ram_wdat_o,
  output logic [eth_slot_pkg::SLOT_DW/8-1:0]    ram_be_o,
  output logic                                  ram_we_o,
  input  logic [eth_slot_pkg::SLOT_DW-1:0]      ram_rdat_i,
  output logic                                  rx_frame_irq_o
);

  import host_map_pkg::*;
  import eth_slot_pkg::*;

  logic [2:0]         region;
  logic [2:0]         reg_idx;
  logic               reg_hit;
  logic               win_hit;
  logic               req;
  logic               rd;
  logic               wr;
  logic               global_wr;
  logic               status_wr;
  logic [BUS_DW-1:0]  rd_mux;

  logic               ack_q;
  logic [1:0]         wait_q;
  logic [3:0]         status_q;
  logic               irq_q;
  logic               ram_we_q;
  logic [BUS_DW-1:0]  dat_q;
  logic [SLOT_AW-1:0] ram_addr_q;
  logic [SLOT_DW-1:0] ram_wdat_q;
  logic [1:0]         ram_be_q;

  // ------------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------------
  assign region  = bus_adr_i[15:13];
  assign reg_idx = bus_adr_i[3:1];
  assign reg_hit = (bus_adr_i[12:4] == 9'd0);
  assign win_hit = (region == REGION_RX1) && !reg_hit;

  // one request per ack
  assign req = bus_cyc_i && bus_stb_i && !ack_q;
  assign rd  = req && !bus_we_i;
  assign wr  = req && bus_we_i;

  assign global_wr = wr && (region == REGION_GLOBAL) && reg_hit;
  assign status_wr = global_wr && (reg_idx == REG_SLOT_STATUS) && bus_sel_i[1];

  // counter lane writes go straight to the timer
  always_comb begin
    lane_we_o = 4'b0000;
    if (global_wr) begin
      case (reg_idx)
        REG_COUNTER_0: lane_we_o[0] = 1'b1;
        REG_COUNTER_1: lane_we_o[1] = 1'b1;
        REG_COUNTER_2: lane_we_o[2] = 1'b1;
        REG_COUNTER_3: lane_we_o[3] = 1'b1;
        default:       lane_we_o = 4'b0000;
      endcase
    end
  end

  assign lane_sel_o = bus_sel_i;
  assign lane_dat_o = bus_dat_i;

  // register read mux, unmapped space reads zero
  always_comb begin
    rd_mux = '0;
    if (reg_hit && region == REGION_GLOBAL) begin
      case (reg_idx)
        REG_SLOT_STATUS: rd_mux = {{(BUS_DW-4){1'b0}}, status_q};
        REG_COUNTER_0:   rd_mux = count_i.lane[0];
        REG_COUNTER_1:   rd_mux = count_i.lane[1];
        REG_COUNTER_2:   rd_mux = count_i.lane[2];
        REG_COUNTER_3:   rd_mux = count_i.lane[3];
        default:         rd_mux = '0;
      endcase
    end else if (reg_hit && region == REGION_RX1) begin
      case (reg_idx)
        REG_RX_TS_0: rd_mux = rx_timestamp_i.lane[0];
        REG_RX_TS_1: rd_mux = rx_timestamp_i.lane[1];
        REG_RX_TS_2: rd_mux = rx_timestamp_i.lane[2];
        REG_RX_TS_3: rd_mux = rx_timestamp_i.lane[3];
        REG_RX_LEN:  rd_mux = {{(BUS_DW-FRAME_LEN_W){1'b0}}, rx_frame_len_i};
        default:     rd_mux = '0;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // ack, slot read wait and status
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      ack_q    <= 1'b0;
      wait_q   <= 2'd0;
      status_q <= 4'd0;
      irq_q    <= 1'b0;
      ram_we_q <= 1'b0;
    end else begin
      ack_q    <= 1'b0;
      ram_we_q <= 1'b0;
      irq_q    <= frame_ready_i;
      if (rd && win_hit) begin
        // address out, ram read, then capture
        if (wait_q == 2'd2) begin
          ack_q  <= 1'b1;
          wait_q <= 2'd0;
        end else begin
          wait_q <= wait_q + 2'd1;
        end
      end else if (req) begin
        ack_q <= 1'b1;
        if (wr && win_hit) begin
          ram_we_q <= 1'b1;
        end
      end
      if (status_wr) begin
        status_q <= bus_dat_i[3:0];
      end
      if (frame_ready_i) begin
        status_q[STATUS_FULL_BIT]  <= 1'b1;
        status_q[STATUS_EMPTY_BIT] <= 1'b0;
      end
    end
  end

  // data path
  always_ff @(posedge clk_125) begin
    if (rd && win_hit && wait_q == 2'd0) begin
      ram_addr_q <= bus_adr_i[SLOT_AW:1];
    end
    if (wr && win_hit) begin
      ram_addr_q <= bus_adr_i[SLOT_AW:1];
      ram_wdat_q <= bus_dat_i;
      ram_be_q   <= {bus_sel_i[0], bus_sel_i[1]};
    end
    if (rd && win_hit && wait_q == 2'd2) begin
      dat_q <= ram_rdat_i;
    end else if (rd && !win_hit) begin
      dat_q <= rd_mux;
    end
  end

  assign bus_dat_o      = dat_q;
  assign bus_ack_o      = ack_q;
  assign slot_empty_o   = status_q[STATUS_EMPTY_BIT];
  assign rx_frame_irq_o = irq_q;
  assign ram_addr_o     = ram_addr_q;
  assign ram_wdat_o     = ram_wdat_q;
  assign ram_be_o       = ram_be_q;
  assign ram_we_o       = ram_we_q;

  ack_single_cycle : assert property (
    @(posedge clk_125) disable iff (!core_rst_n) ack_q |=> !ack_q
  );

endmodule

// ==== rtl/global_timer.sv ====
module global_timer (
  input  logic                                clk_125,
  input  logic                                core_rst_n,
  input  logic [3:0]                          lane_we_i,
  input  logic [host_map_pkg::BUS_SELW-1:0]   lane_sel_i,
  input  logic [host_map_pkg::BUS_DW-1:0]     lane_dat_i,
  output host_map_pkg::counter_word_u         count_o
);

  import host_map_pkg::*;

  counter_word_u cnt_q;
  counter_word_u cnt_nxt;

  // free-running increment, host lane writes override single bytes
  always_comb begin
    cnt_nxt.count = cnt_q.count + 64'd1;
    for (int i = 0; i < 4; i++) begin
      if (lane_we_i[i]) begin
        // sel bit 0 is the upper byte of the bus word
        if (lane_sel_i[0]) begin
          cnt_nxt.lane[i][15:8] = lane_dat_i[15:8];
        end
        if (lane_sel_i[1]) begin
          cnt_nxt.lane[i][7:0] = lane_dat_i[7:0];
        end
      end
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      cnt_q.count <= 64'd0;
    end else begin
      cnt_q <= cnt_nxt;
    end
  end

  assign count_o = cnt_q;

endmodule

// ==== common/eth_slot_pkg.sv ====
package eth_slot_pkg;

  // ------------------------------------------------------------------------
  // slot memory geometry
  // ------------------------------------------------------------------------
  localparam int SLOT_AW = 12;
  localparam int SLOT_DW = 16;

  // frame length register and the largest stored length
  localparam int FRAME_LEN_W     = 12;
  localparam int MAX_FRAME_BYTES = 4095;

  // ------------------------------------------------------------------------
  // GMII framing
  // ------------------------------------------------------------------------
  localparam logic [7:0] GMII_PREAMBLE = 8'h55;
  localparam logic [7:0] GMII_SFD      = 8'hD5;

  // slot status bits
  // 01 means a frame is waiting, 10 means the host released the slot
  localparam int STATUS_FULL_BIT  = 0;
  localparam int STATUS_EMPTY_BIT = 1;

endpackage

// ==== common/host_map_pkg.sv ====
package host_map_pkg;

  // ------------------------------------------------------------------------
  // host bus geometry
  // ------------------------------------------------------------------------
  localparam int BUS_DW   = 16;
  localparam int BUS_AW   = 16;
  localparam int BUS_SELW = 2;

  // region codes, address bits 15..13
  localparam logic [2:0] REGION_GLOBAL = 3'd0;
  localparam logic [2:0] REGION_RX1    = 3'd4;

  // ------------------------------------------------------------------------
  // register indexes, address bits 3..1
  // ------------------------------------------------------------------------
  // global region
  localparam logic [2:0] REG_SLOT_STATUS = 3'd0;
  localparam logic [2:0] REG_COUNTER_0   = 3'd1;
  localparam logic [2:0] REG_COUNTER_1   = 3'd2;
  localparam logic [2:0] REG_COUNTER_2   = 3'd3;
  localparam logic [2:0] REG_COUNTER_3   = 3'd4;

  // rx1 region
  localparam logic [2:0] REG_RX_TS_0 = 3'd0;
  localparam logic [2:0] REG_RX_TS_1 = 3'd1;
  localparam logic [2:0] REG_RX_TS_2 = 3'd2;
  localparam logic [2:0] REG_RX_TS_3 = 3'd3;
  localparam logic [2:0] REG_RX_LEN  = 3'd4;

  // counter and timestamp word
  // lane 0 is the least significant 16 bits
  typedef union packed {
    logic [63:0]       count;
    logic [3:0][15:0]  lane;
  } counter_word_u;

endpackage
